/* Makefile */
# Verilator build of the fetch subsystem testbench

SIM = obj_dir/sim_fetch

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module fetch_tb -f all.f -o sim_fetch
	./$(SIM) +verilator+error+limit+100000 | tee /dev/stderr | \
		grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

/* all.f */
design/icache_pkg.sv
design/fetch_pc_gen.sv
design/icache_ways.sv
design/icache.sv
design/fetch_buffer.sv
design/fetch_top.sv
tests/fetch_chk.sv
tests/fetch_tb.sv

/* design/fetch_buffer.sv */
`timescale 1ns/1ps

module fetch_buffer #(
    parameter int BUF_DEPTH = 4
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      flush,
    input  logic                      in_valid,
    input  icache_pkg::fetch_bundle_t in_bundle,
    input  logic                      out_ready,
    output logic                      in_ready,
    output logic                      out_valid,
    output icache_pkg::fetch_bundle_t out_bundle
);
    import icache_pkg::*;

    localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
    localparam int CNT_W = $clog2(BUF_DEPTH + 1);

    fetch_bundle_t    mem [BUF_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // wraps for any depth
    function automatic logic [PTR_W-1:0] bump(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(BUF_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign in_ready   = count != CNT_W'(BUF_DEPTH);
    assign out_valid  = count != '0;
    assign out_bundle = mem[rd_ptr];
    assign push       = in_valid && in_ready;
    assign pop        = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_bundle;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;                            // emptied in one cycle
        end else begin
            if (push) begin
                wr_ptr <= bump(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= bump(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* design/fetch_pc_gen.sv */
`timescale 1ns/1ps

module fetch_pc_gen #(
    parameter logic [31:0] RESET_PC = 32'h0000_1000
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stall,
    input  logic                   redirect_valid,
    input  icache_pkg::addr_t      redirect_pc,
    output logic                   fetch_valid,
    output icache_pkg::fetch_req_t fetch_req
);
    import icache_pkg::*;

    addr_t       pc;
    logic        running;
    logic        last_word;
    logic        uncached;
    logic [31:0] step;

    assign last_word = pc.fields.word == WORD_SEL_W'(WORDS_PER_LINE - 1);
    assign uncached  = pc.raw[31];

    // slot b never leaves the line
    assign step = (uncached || last_word) ? 32'd4 : 32'd8;

    // nothing is offered while the pc is replaced
    assign fetch_valid  = running && !redirect_valid;
    assign fetch_req.pc = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            pc.raw  <= RESET_PC;
        end else begin
            running <= 1'b1;
            if (redirect_valid) begin
                pc <= redirect_pc;
            end else if (fetch_valid && !stall) begin
                pc.raw <= pc.raw + step;             // held while stalled
            end
        end
    end

endmodule

/* design/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top #(
    parameter logic [31:0] RESET_PC  = 32'h0000_1000,
    parameter int          BUF_DEPTH = 4
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      redirect_valid,
    input  icache_pkg::addr_t         redirect_pc,
    input  logic                      out_ready,
    input  logic                      mem_ack,
    input  icache_pkg::line_t         mem_line,
    output logic                      out_valid,
    output icache_pkg::fetch_bundle_t out_bundle,
    output logic                      mem_req,
    output icache_pkg::mem_req_t      mem_req_data
);
    import icache_pkg::*;

    logic          fetch_valid;
    fetch_req_t    fetch_req;
    logic          stall;
    logic          bundle_valid;
    fetch_bundle_t bundle;
    logic          buf_ready;

    fetch_pc_gen #(
        .RESET_PC (RESET_PC)
    ) pc_gen_i (
        .clk            (clk),
        .reset          (reset),
        .stall          (stall),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .fetch_valid    (fetch_valid),
        .fetch_req      (fetch_req)
    );

    icache icache_i (
        .clk            (clk),
        .reset          (reset),
        .fetch_valid    (fetch_valid),
        .fetch_req      (fetch_req),
        .redirect_valid (redirect_valid),
        .buf_ready      (buf_ready),
        .mem_ack        (mem_ack),
        .mem_line       (mem_line),
        .stall          (stall),
        .bundle_valid   (bundle_valid),
        .bundle         (bundle),
        .mem_req        (mem_req),
        .mem_req_data   (mem_req_data)
    );

    fetch_buffer #(
        .BUF_DEPTH (BUF_DEPTH)
    ) buffer_i (
        .clk        (clk),
        .reset      (reset),
        .flush      (redirect_valid),                // wrong-path bundles go too
        .in_valid   (bundle_valid),
        .in_bundle  (bundle),
        .out_ready  (out_ready),
        .in_ready   (buf_ready),
        .out_valid  (out_valid),
        .out_bundle (out_bundle)
    );

endmodule

/* design/icache.sv */
`timescale 1ns/1ps

module icache (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      fetch_valid,
    input  icache_pkg::fetch_req_t    fetch_req,
    input  logic                      redirect_valid,
    input  logic                      buf_ready,
    input  logic                      mem_ack,
    input  icache_pkg::line_t         mem_line,
    output logic                      stall,
    output logic                      bundle_valid,
    output icache_pkg::fetch_bundle_t bundle,
    output logic                      mem_req,
    output icache_pkg::mem_req_t      mem_req_data
);
    import icache_pkg::*;

    localparam logic [4:0] S_LOOKUP     = 5'b00001;
    localparam logic [4:0] S_REFILL_REQ = 5'b00010;
    localparam logic [4:0] S_REFILL_REL = 5'b00100;
    localparam logic [4:0] S_UNC_REQ    = 5'b01000;
    localparam logic [4:0] S_UNC_REL    = 5'b10000;

    logic [4:0]            state;
    logic [4:0]            next_state;
    logic                  lk_valid;
    addr_t                 lk_pc;
    logic                  lk_unc;
    logic                  lk_last;
    logic [WORD_SEL_W-1:0] next_word;
    logic                  out_free;
    logic                  accept;
    logic                  lk_done;
    logic                  unc_done;
    logic [INDEX_W-1:0]    rd_index;
    logic                  wr_en;
    logic                  hit;
    line_t                 hit_line;
    logic [31:0]           unc_word;

    assign lk_unc    = lk_pc.raw[31];
    assign lk_last   = lk_pc.fields.word == WORD_SEL_W'(WORDS_PER_LINE - 1);
    assign next_word = lk_pc.fields.word + 1'b1;
    assign out_free  = !bundle_valid || buf_ready;

    assign lk_done  = state == S_LOOKUP && lk_valid && !lk_unc && hit && out_free;
    assign unc_done = state == S_UNC_REL && !mem_ack && lk_valid && out_free;

    // a new pc only when the lookup slot frees up this cycle
    assign stall  = !(state == S_LOOKUP && (!lk_valid || lk_done));
    assign accept = fetch_valid && !stall;

    // re-read the held pc so the tags stay current
    assign rd_index = accept ? fetch_req.pc.fields.index : lk_pc.fields.index;
    assign wr_en    = state == S_REFILL_REQ && mem_ack;

    icache_ways ways_i (
        .clk       (clk),
        .reset     (reset),
        .rd_index  (rd_index),
        .wr_en     (wr_en),
        .wr_index  (lk_pc.fields.index),
        .wr_tag    (lk_pc.fields.tag),
        .wr_line   (mem_line),
        .cmp_tag   (lk_pc.fields.tag),
        .lru_touch (lk_done),
        .hit       (hit),
        .hit_line  (hit_line)
    );

    assign mem_req               = state == S_REFILL_REQ || state == S_UNC_REQ;
    assign mem_req_data.uncached = lk_unc;
    assign mem_req_data.addr     = lk_unc ? {lk_pc.raw[31:2], 2'b00}
                                          : {lk_pc.fields.tag, lk_pc.fields.index, 5'd0};

    always_comb begin
        next_state = state;
        case (state)
            S_LOOKUP: begin
                if (lk_valid && !redirect_valid) begin
                    if (lk_unc) begin
                        next_state = S_UNC_REQ;     // bypass straight to memory
                    end else if (!hit) begin
                        next_state = S_REFILL_REQ;
                    end
                end
            end
            S_REFILL_REQ: begin
                if (mem_ack) begin
                    next_state = S_REFILL_REL;
                end
            end
            S_REFILL_REL: begin
                if (!mem_ack) begin
                    next_state = S_LOOKUP;          // replay hits next cycle
                end
            end
            S_UNC_REQ: begin
                if (mem_ack) begin
                    next_state = S_UNC_REL;
                end
            end
            S_UNC_REL: begin
                if (!mem_ack && (!lk_valid || redirect_valid || out_free)) begin
                    next_state = S_LOOKUP;
                end
            end
            default: next_state = S_LOOKUP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= S_LOOKUP;
            lk_valid     <= 1'b0;
            lk_pc.raw    <= '0;
            bundle_valid <= 1'b0;
        end else begin
            state <= next_state;
            if (accept) begin
                lk_pc <= fetch_req.pc;               // kept through a refill
            end
            if (redirect_valid) begin
                lk_valid <= 1'b0;                    // drop the lookup in flight
            end else if (accept) begin
                lk_valid <= 1'b1;
            end else if (lk_done || unc_done) begin
                lk_valid <= 1'b0;
            end
            if (redirect_valid) begin
                bundle_valid <= 1'b0;
            end else if (lk_done || unc_done) begin
                bundle_valid <= 1'b1;
            end else if (buf_ready) begin
                bundle_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_UNC_REQ && mem_ack) begin
            unc_word <= mem_line[lk_pc.fields.word];
        end
        if (lk_done) begin
            bundle.pc    <= lk_pc.raw;
            bundle.inst0 <= hit_line[lk_pc.fields.word];
            bundle.inst1 <= lk_last ? 32'd0 : hit_line[next_word];
            bundle.mask  <= lk_last ? 2'b01 : 2'b11;
        end else if (unc_done) begin
            bundle.pc    <= lk_pc.raw;
            bundle.inst0 <= unc_word;
            bundle.inst1 <= 32'd0;
            bundle.mask  <= 2'b01;                   // single word
        end
    end

endmodule

/* design/icache_pkg.sv */
package icache_pkg;

    // cache geometry
    localparam int INDEX_W        = 7;
    localparam int TAG_W          = 20;
    localparam int WORDS_PER_LINE = 8;
    localparam int WORD_SEL_W     = $clog2(WORDS_PER_LINE);

    // 32-byte line split of a fetch address
    typedef struct packed {
        logic [TAG_W-1:0]      tag;
        logic [INDEX_W-1:0]    index;
        logic [WORD_SEL_W-1:0] word;
        logic [1:0]            byte_off;
    } addr_fields_t;

    typedef union packed {
        logic [31:0]  raw;
        addr_fields_t fields;
    } addr_t;

    typedef logic [WORDS_PER_LINE-1:0][31:0] line_t;    // word 0 in the low bits

    // producer to cache
    typedef struct packed {
        addr_t pc;
    } fetch_req_t;

    // up to two instructions from one line
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst0;                             // word at pc
        logic [31:0] inst1;                             // word at pc+4
        logic [1:0]  mask;                              // bit 0 for inst0
    } fetch_bundle_t;

    // memory port request held while req is high
    typedef struct packed {
        logic [31:0] addr;                              // line or word aligned
        logic        uncached;
    } mem_req_t;

endpackage

/* design/icache_ways.sv */
`timescale 1ns/1ps

module icache_ways (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [icache_pkg::INDEX_W-1:0] rd_index,
    input  logic                           wr_en,
    input  logic [icache_pkg::INDEX_W-1:0] wr_index,
    input  logic [icache_pkg::TAG_W-1:0]   wr_tag,
    input  icache_pkg::line_t              wr_line,
    input  logic [icache_pkg::TAG_W-1:0]   cmp_tag,
    input  logic                           lru_touch,
    output logic                           hit,
    output icache_pkg::line_t              hit_line
);
    import icache_pkg::*;

    localparam int SETS = 1 << INDEX_W;

    logic [TAG_W-1:0]   tag_mem  [2][SETS];
    line_t              data_mem [2][SETS];
    logic [SETS-1:0]    valid    [2];
    logic [SETS-1:0]    lru;                         // way to replace next

    logic [TAG_W-1:0]   rd_tag  [2];
    line_t              rd_line [2];
    logic [1:0]         rd_valid;
    logic [INDEX_W-1:0] rd_index_q;
    logic [1:0]         way_hit;
    logic               victim;

    assign victim = lru[wr_index];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[victim][wr_index]  <= wr_tag;
            data_mem[victim][wr_index] <= wr_line;
        end
        for (int w = 0; w < 2; w++) begin
            rd_tag[w]  <= tag_mem[w][rd_index];
            rd_line[w] <= data_mem[w][rd_index];
        end
        rd_index_q <= rd_index;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid[0] <= '0;
            valid[1] <= '0;
            rd_valid <= 2'b00;
            lru      <= '0;
        end else begin
            if (wr_en) begin
                valid[victim][wr_index] <= 1'b1;
            end
            rd_valid <= {valid[1][rd_index], valid[0][rd_index]};
            if (wr_en) begin
                lru[wr_index] <= ~victim;           // filled way is now newest
            end else if (lru_touch && hit) begin
                lru[rd_index_q] <= way_hit[0];      // the other way goes next
            end
        end
    end

    // compare on the registered read
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = rd_valid[w] && (rd_tag[w] == cmp_tag);
        end
    end

    assign hit      = |way_hit;
    assign hit_line = way_hit[1] ? rd_line[1] : rd_line[0];

endmodule

/* tests/fetch_chk.sv */
`timescale 1ns/1ps

module fetch_chk #(
    parameter logic [31:0] RESET_PC = 32'h0000_1000
) (
    input logic                      clk,
    input logic                      reset,
    input logic                      redirect_valid,
    input icache_pkg::addr_t         redirect_pc,
    input logic                      out_ready,
    input logic                      mem_ack,
    input logic                      out_valid,
    input icache_pkg::fetch_bundle_t out_bundle,
    input logic                      mem_req,
    input icache_pkg::mem_req_t      mem_req_data
);
    import icache_pkg::*;

    int          fail_count = 0;
    logic [31:0] exp_pc;
    logic        single;

    // one word only at a line end or outside the cache
    assign single = out_bundle.pc[31] || out_bundle.pc[4:2] == 3'd7;

    always_ff @(posedge clk) begin
        if (reset) begin
            exp_pc <= RESET_PC;
        end else if (redirect_valid) begin
            exp_pc <= redirect_pc.raw;
        end else if (out_valid && out_ready) begin
            exp_pc <= out_bundle.pc + (single ? 32'd4 : 32'd8);
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        out_valid |-> out_bundle.inst0 == ~out_bundle.pc)
        else begin
            $error("error out_bundle.inst0 %h expected %h", $sampled(out_bundle.inst0),
                   ~$sampled(out_bundle.pc));
            fail_count++;
        end
    assert property (@(posedge clk) disable iff (reset)
        out_valid && out_bundle.mask[1] |-> out_bundle.inst1 == ~(out_bundle.pc + 32'd4))
        else begin
            $error("error out_bundle.inst1 %h expected %h", $sampled(out_bundle.inst1),
                   ~($sampled(out_bundle.pc) + 32'd4));
            fail_count++;
        end
    assert property (@(posedge clk) disable iff (reset)
        out_valid |-> out_bundle.mask == (single ? 2'b01 : 2'b11))
        else begin
            $error("error out_bundle.mask %h expected %h", $sampled(out_bundle.mask),
                   $sampled(single) ? 2'b01 : 2'b11);
            fail_count++;
        end
    assert property (@(posedge clk) disable iff (reset)
        out_valid |-> out_bundle.pc == exp_pc)
        else begin
            $error("error out_bundle.pc %h expected %h", $sampled(out_bundle.pc),
                   $sampled(exp_pc));
            fail_count++;
        end
    assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready && !redirect_valid |=> out_valid && $stable(out_bundle))
        else begin
            $error("bundle changed or vanished while held");
            fail_count++;
        end
    assert property (@(posedge clk) disable iff (reset)
        mem_req && !mem_ack |=> mem_req && $stable(mem_req_data))
        else begin
            $error("memory request dropped or changed before ack");
            fail_count++;
        end
    assert property (@(posedge clk) disable iff (reset)
        $fell(mem_req) |-> $past(mem_ack))
        else begin
            $error("memory request fell without ack");
            fail_count++;
        end
    assert property (@(posedge clk) disable iff (reset)
        $rose(mem_req) |-> !mem_ack)
        else begin
            $error("memory request rose while ack high");
            fail_count++;
        end
    assert property (@(posedge clk) disable iff (reset)
        mem_req && !mem_req_data.uncached
            |-> mem_req_data.addr[4:0] == 5'd0 && !mem_req_data.addr[31])
        else begin
            $error("error mem_req_data.addr %h for refill", $sampled(mem_req_data.addr));
            fail_count++;
        end
    assert property (@(posedge clk) disable iff (reset)
        mem_req && mem_req_data.uncached |-> mem_req_data.addr[31])
        else begin
            $error("error mem_req_data.addr %h for uncached read",
                   $sampled(mem_req_data.addr));
            fail_count++;
        end
    assert property (@(posedge clk)
        reset && $past(reset) |-> !out_valid && !mem_req)
        else begin
            $error("out_valid or mem_req active in reset");
            fail_count++;
        end
    assert property (@(posedge clk)
        $fell(reset) |-> !out_valid && !mem_req)
        else begin
            $error("out_valid or mem_req active right after reset");
            fail_count++;
        end

endmodule

/* tests/fetch_tb.sv */
`timescale 1ns/1ps

module fetch_tb;
    import icache_pkg::*;

    localparam logic [31:0] LOOP_START = 32'h0000_1000;
    localparam logic [31:0] LOOP_END   = 32'h0000_1C00;    // 3 kB of straight code

    logic          clk;
    logic          reset;
    logic          redirect_valid;
    addr_t         redirect_pc;
    logic          out_ready;
    logic          mem_ack;
    line_t         mem_line;
    logic          out_valid;
    fetch_bundle_t out_bundle;
    logic          mem_req;
    mem_req_t      mem_req_data;

    logic          hold_low;
    logic          counting;
    logic          req_q;
    int            loop_refills;
    int            reuse_errors;
    int            timeouts;

    fetch_top #(
        .RESET_PC  (32'h0000_1000),
        .BUF_DEPTH (4)
    ) dut_i (
        .clk            (clk),
        .reset          (reset),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .out_ready      (out_ready),
        .mem_ack        (mem_ack),
        .mem_line       (mem_line),
        .out_valid      (out_valid),
        .out_bundle     (out_bundle),
        .mem_req        (mem_req),
        .mem_req_data   (mem_req_data)
    );

    always #4 clk = ~clk;

    // every word holds the inverse of its byte address
    function automatic line_t line_fill(input logic [31:0] addr);
        line_t l;
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            l[i] = ~({addr[31:5], 5'd0} + 32'(4 * i));
        end
        return l;
    endfunction

    // four-phase memory model with 1 to 6 cycles to ack
    always begin
        int delay;
        int n;
        @(posedge clk);
        if (mem_req && !mem_ack) begin
            delay = $urandom_range(1, 6);
            repeat (delay - 1) @(posedge clk);
            @(negedge clk);
            mem_line = line_fill(mem_req_data.addr);
            mem_ack  = 1'b1;
            n = 0;
            while (mem_req && n < 100) begin
                @(posedge clk);
                n++;
            end
            if (n >= 100) begin
                $display("memory request never released after ack");
                timeouts++;
            end
            @(negedge clk);
            mem_ack = 1'b0;
        end
    end

    // consumer ready about 75% of the time
    always @(negedge clk) begin
        out_ready = hold_low ? 1'b0 : ($urandom_range(0, 3) != 0);
    end

    // refills of loop lines after the first pass
    always @(posedge clk) begin
        req_q <= mem_req;
        if (counting && mem_req && !req_q && mem_req_data.addr >= LOOP_START
                && mem_req_data.addr < LOOP_END) begin
            loop_refills <= loop_refills + 1;
        end
    end

    task automatic redirect_to(input logic [31:0] pc);
        @(negedge clk);
        redirect_valid  = 1'b1;
        redirect_pc.raw = pc;
        @(negedge clk);
        redirect_valid  = 1'b0;
    endtask

    // last bundle of the loop is at 0x1bf8 or 0x1bfc
    task automatic wait_loop_end();
        int n;
        n = 0;
        while (!(out_valid && out_ready && out_bundle.pc >= LOOP_END - 8
                && out_bundle.pc < LOOP_END) && n < 20000) begin
            @(posedge clk);
            n++;
        end
        if (n >= 20000) begin
            $display("timeout waiting for the end of the loop");
            timeouts++;
        end
    endtask

    task automatic wait_pops(input int count);
        int n;
        int seen;
        n    = 0;
        seen = 0;
        while (seen < count && n < 2000) begin
            @(posedge clk);
            if (out_valid && out_ready) begin
                seen++;
            end
            n++;
        end
        if (n >= 2000) begin
            $display("timeout waiting for %0d bundles", count);
            timeouts++;
        end
    endtask

    initial begin
        void'($urandom(73));
        clk            = 1'b0;
        reset          = 1'b1;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        out_ready      = 1'b0;
        mem_ack        = 1'b0;
        mem_line       = '0;
        hold_low       = 1'b0;
        counting       = 1'b0;
        loop_refills   = 0;
        reuse_errors   = 0;
        timeouts       = 0;
        repeat (8) @(negedge clk);
        reset = 1'b0;

        wait_loop_end();                                // first pass fills the cache
        if (timeouts == 0) begin
            counting = 1'b1;
            redirect_to(LOOP_START);
            hold_low = 1'b1;                            // back-pressure up to the producer
            repeat (40) @(negedge clk);
            hold_low = 1'b0;
            wait_loop_end();
        end
        if (timeouts == 0) begin
            redirect_to(LOOP_START);
            wait_loop_end();
            counting = 1'b0;
            assert (loop_refills == 0) else begin
                $error("error loop_refills %h expected %h", loop_refills, 0);
                reuse_errors++;
            end
        end
        if (timeouts == 0) begin
            redirect_to(32'h8000_0100);                 // uncached region
            wait_pops(12);
        end
        repeat (4) @(negedge clk);

        $display("errors: %0d assertion, %0d hit reuse, %0d timeout",
                 dut_i.chk_i.fail_count, reuse_errors, timeouts);
        if (dut_i.chk_i.fail_count == 0 && reuse_errors == 0 && timeouts == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

bind fetch_top fetch_chk #(.RESET_PC(RESET_PC)) chk_i (
    .clk            (clk),
    .reset          (reset),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .out_ready      (out_ready),
    .mem_ack        (mem_ack),
    .out_valid      (out_valid),
    .out_bundle     (out_bundle),
    .mem_req        (mem_req),
    .mem_req_data   (mem_req_data)
);
